// File: Makefile
# Verilator build and run of the out-of-order multiply back end

OBJ := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module ooo_mul_tb --Mdir $(OBJ) -o ooo_mul_sim
	./$(OBJ)/ooo_mul_sim | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf $(OBJ) sim.log

// File: flist.f
verilog/mul_rob_pkg.sv
verilog/mul_issue.sv
verilog/mul_lane.sv
verilog/complete_arbiter.sv
verilog/reorder_buffer.sv
verilog/ooo_mul_top.sv
verif/ooo_mul_tb.sv

// File: verif/mul_input.dat
// One request per line, hex: write address, operand a, operand b, expected product
// Address 00 writes no register
01 03 05 000f
02 ff ff fe01
03 07 01 0007
00 10 10 0100
00 00 80 0000
04 0c 02 0018
05 ab 00 0000
// Same register, must stall and commit in order
09 02 03 0006
09 11 11 0121
09 20 08 0100
09 c8 02 0190
00 05 05 0019
00 06 07 002a
// Burst of slow operands, more than the buffer holds
0a 81 ff 807f
0b 7f fe 7e02
0c 99 f0 8f70
0d 55 aa 3872
0e ff 80 7f80
0f 12 c3 0db6
10 e0 e0 c400
11 3c 9d 24cc
12 fe 02 01fc
13 01 ff 00ff
// Mixed tail
14 64 64 2710
14 02 01 0002
00 ff 01 00ff
1f 0a 0b 006e

// File: verif/ooo_mul_tb.sv
/*
 * Testbench for the out-of-order multiply back end
 * Vector file requests with LFSR idle gaps and a scoreboard on the commit port
 */

`timescale 1ns/10ps

module ooo_mul_tb import mul_rob_pkg::*; ();

  localparam int          NUM_VEC        = 27;
  // Burst of slow operands driven back to back
  localparam int          BURST_LO       = 13;
  localparam int          BURST_HI       = 22;
  localparam int          ACCEPT_TIMEOUT = 500;
  localparam int          DRAIN_TIMEOUT  = 2000;
  localparam logic [15:0] LFSR_SEED      = 16'd27568;

  logic      clk;
  logic      rst;
  logic      in_val;
  reg_addr_t in_waddr;
  operand_t  in_a;
  operand_t  in_b;
  logic      in_rdy;
  logic      commit_val;
  seq_num_t  commit_seq_num;
  reg_addr_t commit_waddr;
  logic      commit_wen;
  product_t  commit_wdata;

  // Address, a, b and product for each request
  logic [15:0] vec_mem [0:4*NUM_VEC-1];

  // Accepted request indices with the oldest first
  int          sb_q [$];
  int          cur_idx;
  int          commit_cnt;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  seq_num_t    exp_seq;
  logic [15:0] lfsr_q;
  logic        timed_out;

  ooo_mul_top uut (
    .clk            (clk),
    .rst            (rst),
    .in_val         (in_val),
    .in_waddr       (in_waddr),
    .in_a           (in_a),
    .in_b           (in_b),
    .in_rdy         (in_rdy),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .commit_waddr   (commit_waddr),
    .commit_wen     (commit_wen),
    .commit_wdata   (commit_wdata)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic lfsr_next_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  task automatic check_field(input string test, input string field, input int exp,
                             input int act);
    assert (exp == act) else begin
      $display("error %s %s: expected %0h actual %0h", test, field, exp, act);
      err_cnt++;
    end
  endtask

  // One result line per test
  task automatic finish_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s ok", name);
    end else begin
      fail_cnt++;
      $display("test %s failed", name);
    end
  endtask

  // --------------------------------------------------
  // Commit monitor
  // --------------------------------------------------

  always @(posedge clk) begin : monitor
    int    idx;
    int    errs;
    string name;
    if (!rst) begin
      if (commit_val) begin
        errs = err_cnt;
        name = $sformatf("commit_%0d", commit_cnt);
        if (sb_q.size() == 0) begin
          $display("%s: commit seen with no request outstanding", name);
          err_cnt++;
        end else begin
          // Oldest accepted request must retire first
          idx = sb_q.pop_front();
          check_field(name, "data", int'(vec_mem[4*idx+3]), int'(commit_wdata));
          check_field(name, "waddr", int'(vec_mem[4*idx]), int'(commit_waddr));
          // Write only for a nonzero address
          check_field(name, "wen", int'(vec_mem[4*idx] != 16'h0), int'(commit_wen));
          check_field(name, "seq", int'(exp_seq), int'(commit_seq_num));
        end
        finish_test(name, errs);
        exp_seq    <= exp_seq + 1'b1;
        commit_cnt <= commit_cnt + 1;
      end
      if (in_val && in_rdy)
        sb_q.push_back(cur_idx);
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin : stimulus
    int   wait_cyc;
    int   errs;
    logic accepted;
    rst        <= 1'b1;
    in_val     <= 1'b0;
    in_waddr   <= '0;
    in_a       <= '0;
    in_b       <= '0;
    cur_idx    <= 0;
    commit_cnt <= 0;
    exp_seq    <= '0;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    timed_out = 1'b0;
    lfsr_q    = LFSR_SEED;
    $readmemh("verif/mul_input.dat", vec_mem);

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // First cycle out of reset
    @(posedge clk);
    errs = err_cnt;
    check_field("reset_state", "commit_val", 0, int'(commit_val));
    check_field("reset_state", "in_rdy", 1, int'(in_rdy));
    finish_test("reset_state", errs);

    for (int i = 0; i < NUM_VEC && !timed_out; i++) begin
      // Random idle cycle outside the burst
      if ((i < BURST_LO || i > BURST_HI) && lfsr_next_bit()) begin
        in_val <= 1'b0;
        @(posedge clk);
      end
      in_val   <= 1'b1;
      in_waddr <= reg_addr_t'(vec_mem[4*i]);
      in_a     <= operand_t'(vec_mem[4*i+1]);
      in_b     <= operand_t'(vec_mem[4*i+2]);
      cur_idx  <= i;
      wait_cyc = 0;
      accepted = 1'b0;
      while (!accepted && wait_cyc < ACCEPT_TIMEOUT) begin
        @(posedge clk);
        wait_cyc++;
        accepted = in_val && in_rdy;
      end
      if (!accepted) begin
        $display("request %0d was not accepted within %0d cycles", i, ACCEPT_TIMEOUT);
        timed_out = 1'b1;
      end
    end
    in_val <= 1'b0;

    // Drain the buffer
    wait_cyc = 0;
    while (!timed_out && commit_cnt < NUM_VEC && wait_cyc < DRAIN_TIMEOUT) begin
      @(posedge clk);
      wait_cyc++;
    end
    if (commit_cnt < NUM_VEC) begin
      $display("only %0d of %0d requests committed before the drain timeout",
               commit_cnt, NUM_VEC);
      timed_out = 1'b1;
    end

    // Quiet cycles so a stray commit shows up
    repeat (10) @(posedge clk);
    errs = err_cnt;
    check_field("commit_count", "commits", NUM_VEC, commit_cnt);
    finish_test("commit_count", errs);

    $display("tests %0d passed %0d failed %0d errors %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog/complete_arbiter.sv
/*
 * Round-robin completion arbiter
 * One finished lane per cycle goes to the reorder buffer
 */

`timescale 1ns/10ps

module complete_arbiter import mul_rob_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,

  // Finished lanes
  input  logic [NUM_LANES-1:0] done_val,
  input  seq_num_t             done_seq_num [NUM_LANES],
  input  product_t             done_data [NUM_LANES],
  output logic [NUM_LANES-1:0] done_grant,

  // Completion to the buffer
  output logic                 complete_val,
  output seq_num_t             complete_seq_num,
  output product_t             complete_data
);

  // Lane with top priority this cycle
  logic [LANE_BITS-1:0] prio_ptr;
  logic [LANE_BITS-1:0] cand;
  logic [LANE_BITS-1:0] grant_idx;

  // --------------------------------------------------
  // Search from the pointer, wrapping
  // --------------------------------------------------

  always_comb begin
    grant_idx    = prio_ptr;
    complete_val = 1'b0;
    cand         = prio_ptr;
    for (int k = 0; k < NUM_LANES; k++) begin
      cand = prio_ptr + LANE_BITS'(k);
      if (!complete_val && done_val[cand]) begin
        grant_idx    = cand;
        complete_val = 1'b1;
      end
    end
  end

  always_comb begin
    done_grant = '0;
    if (complete_val)
      done_grant[grant_idx] = 1'b1;
  end

  assign complete_seq_num = done_seq_num[grant_idx];
  assign complete_data    = done_data[grant_idx];

  // Rotate past the granted lane
  always_ff @(posedge clk) begin
    if (rst)
      prio_ptr <= '0;
    else if (complete_val)
      prio_ptr <= grant_idx + 1'b1;
  end

endmodule

// File: verilog/mul_issue.sv
/*
 * Issue stage. Admission control, lowest idle lane select
 * and one-hot start to the multiply lanes
 */

`timescale 1ns/10ps

module mul_issue import mul_rob_pkg::*; (
  // Incoming requests
  input  logic                 in_val,
  input  reg_addr_t            in_waddr,
  input  operand_t             in_a,
  input  operand_t             in_b,
  output logic                 in_rdy,

  // Reorder buffer allocation
  input  logic                 alloc_rdy,
  input  seq_num_t             alloc_seq_num,
  output logic                 alloc_val,
  output reg_addr_t            alloc_waddr,

  // Lane control
  input  logic [NUM_LANES-1:0] lane_idle,
  output logic [NUM_LANES-1:0] lane_start,
  output seq_num_t             start_seq_num,
  output operand_t             start_a,
  output operand_t             start_b
);

  logic [LANE_BITS-1:0] sel_lane;
  logic                 any_idle;
  logic                 accept;

  // --------------------------------------------------
  // Lane select
  // --------------------------------------------------

  // Lowest index wins, so scan from the top down
  always_comb begin
    sel_lane = '0;
    for (int k = NUM_LANES - 1; k >= 0; k--) begin
      if (lane_idle[k])
        sel_lane = LANE_BITS'(k);
    end
  end

  assign any_idle = |lane_idle;

  // Buffer slot free, no conflict and a lane to run on
  assign in_rdy = alloc_rdy & any_idle;
  assign accept = in_val & in_rdy;

  // Allocation happens on the accept edge
  assign alloc_val   = accept;
  assign alloc_waddr = in_waddr;

  // --------------------------------------------------
  // Lane start
  // --------------------------------------------------

  always_comb begin
    lane_start = '0;
    if (accept)
      lane_start[sel_lane] = 1'b1;
  end

  // Broadcast payload, only the started lane latches it
  assign start_seq_num = alloc_seq_num;
  assign start_a       = in_a;
  assign start_b       = in_b;

endmodule

// File: verilog/mul_lane.sv
/*
 * One iterative shift-and-add 8x8 multiply lane
 * Holds its tagged result until the completion grant
 */

`timescale 1ns/10ps

module mul_lane import mul_rob_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  // Start from issue
  input  logic        start,
  input  seq_num_t    start_seq_num,
  input  operand_t    start_a,
  input  operand_t    start_b,
  output logic        lane_idle,

  // Result toward the arbiter
  output logic        done_val,
  output seq_num_t    done_seq_num,
  output product_t    done_data,
  input  logic        done_grant
);

  lane_state_t state;

  // Datapath registers
  seq_num_t    seq_q;
  product_t    mcand;
  operand_t    mplier;
  product_t    acc;

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= LANE_IDLE;
    end else begin
      case (state)
        LANE_IDLE:
          if (start)
            state <= LANE_RUN;
        // Last step when no set bits remain above bit 0
        LANE_RUN:
          if ((mplier >> 1) == '0)
            state <= LANE_DONE;
        LANE_DONE:
          if (done_grant)
            state <= LANE_IDLE;
        default:
          state <= LANE_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Shift and add
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (state == LANE_IDLE && start) begin
      seq_q  <= start_seq_num;
      mcand  <= product_t'(start_a);
      mplier <= start_b;
      acc    <= '0;
    end else if (state == LANE_RUN) begin
      // Add shifted multiplicand for each set multiplier bit
      if (mplier[0])
        acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign lane_idle    = (state == LANE_IDLE);
  assign done_val     = (state == LANE_DONE);
  assign done_seq_num = seq_q;
  assign done_data    = acc;

endmodule

// File: verilog/mul_rob_pkg.sv
/*
 * Shared widths, counts and vector types for the multiply back end
 * Lane state encoding
 */

package mul_rob_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------

  // Reorder buffer depth and its index width
  localparam int ROB_ENTRIES = 8;
  localparam int SEQ_BITS    = 3;

  // Multiply lanes and lane index width
  localparam int NUM_LANES   = 4;
  localparam int LANE_BITS   = 2;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------

  // Destination register, zero means no write
  typedef logic [4:0]          reg_addr_t;
  typedef logic [SEQ_BITS-1:0] seq_num_t;

  // Unsigned operands and their full product
  typedef logic [7:0]          operand_t;
  typedef logic [15:0]         product_t;

  // Lane FSM
  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_RUN,
    LANE_DONE
  } lane_state_t;

endpackage

// File: verilog/ooo_mul_top.sv
/*
 * Out-of-order multiply back end top level
 * Issue, lane array, completion arbiter and reorder buffer
 */

`timescale 1ns/10ps

module ooo_mul_top import mul_rob_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Request side
  input  logic      in_val,
  input  reg_addr_t in_waddr,
  input  operand_t  in_a,
  input  operand_t  in_b,
  output logic      in_rdy,

  // Commit side
  output logic      commit_val,
  output seq_num_t  commit_seq_num,
  output reg_addr_t commit_waddr,
  output logic      commit_wen,
  output product_t  commit_wdata
);

  // Issue to buffer
  logic      alloc_rdy;
  logic      alloc_val;
  seq_num_t  alloc_seq_num;
  reg_addr_t alloc_waddr;

  // Issue to lanes
  logic [NUM_LANES-1:0] lane_idle;
  logic [NUM_LANES-1:0] lane_start;
  seq_num_t             start_seq_num;
  operand_t             start_a;
  operand_t             start_b;

  // Lanes to arbiter
  logic [NUM_LANES-1:0] done_val;
  logic [NUM_LANES-1:0] done_grant;
  seq_num_t             done_seq_num [NUM_LANES];
  product_t             done_data [NUM_LANES];

  // Arbiter to buffer
  logic     complete_val;
  seq_num_t complete_seq_num;
  product_t complete_data;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------

  mul_issue u_issue (
    .in_val        (in_val),
    .in_waddr      (in_waddr),
    .in_a          (in_a),
    .in_b          (in_b),
    .in_rdy        (in_rdy),
    .alloc_rdy     (alloc_rdy),
    .alloc_seq_num (alloc_seq_num),
    .alloc_val     (alloc_val),
    .alloc_waddr   (alloc_waddr),
    .lane_idle     (lane_idle),
    .lane_start    (lane_start),
    .start_seq_num (start_seq_num),
    .start_a       (start_a),
    .start_b       (start_b)
  );

  // Identical lanes, each with its own start and grant bit
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    mul_lane u_lane (
      .clk           (clk),
      .rst           (rst),
      .start         (lane_start[g]),
      .start_seq_num (start_seq_num),
      .start_a       (start_a),
      .start_b       (start_b),
      .lane_idle     (lane_idle[g]),
      .done_val      (done_val[g]),
      .done_seq_num  (done_seq_num[g]),
      .done_data     (done_data[g]),
      .done_grant    (done_grant[g])
    );
  end

  complete_arbiter u_arb (
    .clk              (clk),
    .rst              (rst),
    .done_val         (done_val),
    .done_seq_num     (done_seq_num),
    .done_data        (done_data),
    .done_grant       (done_grant),
    .complete_val     (complete_val),
    .complete_seq_num (complete_seq_num),
    .complete_data    (complete_data)
  );

  reorder_buffer u_rob (
    .clk              (clk),
    .rst              (rst),
    .alloc_val        (alloc_val),
    .alloc_waddr      (alloc_waddr),
    .alloc_seq_num    (alloc_seq_num),
    .alloc_rdy        (alloc_rdy),
    .complete_val     (complete_val),
    .complete_seq_num (complete_seq_num),
    .complete_data    (complete_data),
    .commit_val       (commit_val),
    .commit_seq_num   (commit_seq_num),
    .commit_waddr     (commit_waddr),
    .commit_wen       (commit_wen),
    .commit_wdata     (commit_wdata)
  );

endmodule

// File: verilog/reorder_buffer.sv
/*
 * Reorder buffer. Circular entries with a wrap bit, register conflict
 * check at allocation, completion marking and in-order commit
 */

`timescale 1ns/10ps

module reorder_buffer import mul_rob_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Allocation from issue
  input  logic      alloc_val,
  input  reg_addr_t alloc_waddr,
  output seq_num_t  alloc_seq_num,
  output logic      alloc_rdy,

  // Completion from the arbiter
  input  logic      complete_val,
  input  seq_num_t  complete_seq_num,
  input  product_t  complete_data,

  // Retirement
  output logic      commit_val,
  output seq_num_t  commit_seq_num,
  output reg_addr_t commit_waddr,
  output logic      commit_wen,
  output product_t  commit_wdata
);

  // --------------------------------------------------
  // Pointers
  // --------------------------------------------------

  // Extra MSB tells full from empty when indices match
  logic [SEQ_BITS:0] head;
  logic [SEQ_BITS:0] tail;
  seq_num_t          head_idx;
  seq_num_t          tail_idx;
  logic              full;

  // Entry state
  logic [ROB_ENTRIES-1:0] ent_valid;
  logic [ROB_ENTRIES-1:0] ent_done;
  reg_addr_t              ent_waddr [ROB_ENTRIES];
  product_t               ent_data [ROB_ENTRIES];

  logic addr_conflict;
  logic do_alloc;
  logic do_commit;

  assign head_idx = head[SEQ_BITS-1:0];
  assign tail_idx = tail[SEQ_BITS-1:0];
  assign full     = (head_idx == tail_idx) && (head[SEQ_BITS] != tail[SEQ_BITS]);

  // --------------------------------------------------
  // Allocation
  // --------------------------------------------------

  // Any in-flight writer of the same nonzero register blocks
  always_comb begin
    addr_conflict = 1'b0;
    for (int i = 0; i < ROB_ENTRIES; i++) begin
      if (ent_valid[i] && !ent_done[i] && ent_waddr[i] == alloc_waddr)
        addr_conflict = 1'b1;
    end
    if (alloc_waddr == '0)
      addr_conflict = 1'b0;
  end

  assign alloc_rdy     = !full && !addr_conflict;
  assign alloc_seq_num = tail_idx;
  assign do_alloc      = alloc_val && alloc_rdy;

  // Oldest entry retires once complete
  assign do_commit = ent_valid[head_idx] && ent_done[head_idx];

  // --------------------------------------------------
  // Pointer and flag update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head      <= '0;
      tail      <= '0;
      ent_valid <= '0;
      ent_done  <= '0;
    end else begin
      // Clear on commit
      if (do_commit) begin
        ent_valid[head_idx] <= 1'b0;
        ent_done[head_idx]  <= 1'b0;
        head                <= head + 1'b1;
      end
      if (complete_val)
        ent_done[complete_seq_num] <= 1'b1;
      if (do_alloc) begin
        ent_valid[tail_idx] <= 1'b1;
        ent_done[tail_idx]  <= 1'b0;
        tail                <= tail + 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (do_alloc)
      ent_waddr[tail_idx] <= alloc_waddr;
    if (complete_val)
      ent_data[complete_seq_num] <= complete_data;
  end

  // --------------------------------------------------
  // Commit port
  // --------------------------------------------------

  assign commit_val     = do_commit;
  assign commit_seq_num = head_idx;
  assign commit_waddr   = ent_waddr[head_idx];
  assign commit_wen     = (ent_waddr[head_idx] != '0);
  assign commit_wdata   = ent_data[head_idx];

endmodule
